/* filelist.f */
+incdir+design
design/cpu_pkg.sv
design/fetch_stage.sv
design/decode_stage.sv
design/execute_stage.sv
design/memory_stage.sv
design/hazard_unit.sv
design/cpu.sv
verification/tb_cpu.sv

/* run.sh */
#!/bin/sh
# Build the testbench with Verilator, run it and look for the pass line
cd "$(dirname "$0")" &&
verilator --binary -j 0 --top-module tb_cpu -f filelist.f -o tb_cpu_sim &&
./obj_dir/tb_cpu_sim | tee /dev/stderr | grep -x "test passed" > /dev/null &&
echo "simulation ok" ||
{ echo "simulation failed"; exit 1; }

/* verification/tb_cpu.sv */
`timescale 1ns/100ps

module tb_cpu;

    localparam logic [6:0]  OPC_IMM   = 7'h13;
    localparam logic [6:0]  OPC_LOAD  = 7'h03;
    localparam logic [31:0] NOP       = 32'h0000_0013;
    localparam logic [13:0] END_WORD  = 14'h1ff;
    localparam int          MEM_WORDS = 16384;

    logic        clk           = 1'b0;
    logic        arst_n        = 1'b0;
    logic [13:0] isram_addr;
    logic [31:0] isram_dataout = '0;
    logic [13:0] dsram_addr;
    logic [3:0]  dsram_wen;
    logic [31:0] dsram_datain;
    logic [31:0] dsram_dataout = '0;

    logic [31:0] rom [MEM_WORDS];
    logic [31:0] ram [MEM_WORDS];
    logic [31:0] expected [$];
    int          n_inst;
    int          checks;
    int          errors;
    int          timeouts;

    cpu i_cpu (
        .clk(clk),
        .arst_n(arst_n),
        .isram_addr(isram_addr),
        .isram_dataout(isram_dataout),
        .dsram_addr(dsram_addr),
        .dsram_wen(dsram_wen),
        .dsram_datain(dsram_datain),
        .dsram_dataout(dsram_dataout)
    );

    always #20 clk = ~clk;

    ////////////////////////////////////////////////////////////
    // SRAM models with one cycle of read latency

    always @(posedge clk) begin
        isram_dataout <= rom[isram_addr];
    end

    always @(posedge clk) begin
        if (dsram_wen != 4'd0) begin
            ram[dsram_addr] <= dsram_datain;
        end
        dsram_dataout <= ram[dsram_addr];
    end

    ////////////////////////////////////////////////////////////
    // Instruction encoding

    function automatic logic [31:0] rtype(input logic [6:0] f7, input logic [4:0] rs2,
                                          input logic [4:0] rs1, input logic [2:0] f3,
                                          input logic [4:0] rd);
        return {f7, rs2, rs1, f3, rd, 7'h33};
    endfunction

    function automatic logic [31:0] itype(input logic [11:0] imm, input logic [4:0] rs1,
                                          input logic [2:0] f3, input logic [4:0] rd,
                                          input logic [6:0] opc);
        return {imm, rs1, f3, rd, opc};
    endfunction

    function automatic logic [31:0] stype(input logic [11:0] imm, input logic [4:0] rs2,
                                          input logic [4:0] rs1);
        return {imm[11:5], rs2, rs1, 3'd2, imm[4:0], 7'h23};
    endfunction

    function automatic logic [31:0] btype(input logic [12:0] off, input logic [4:0] rs2,
                                          input logic [4:0] rs1, input logic [2:0] f3);
        return {off[12], off[10:5], rs2, rs1, f3, off[4:1], off[11], 7'h63};
    endfunction

    function automatic logic [31:0] utype(input logic [19:0] upper, input logic [4:0] rd);
        return {upper, rd, 7'h37};
    endfunction

    // Expected results straight from the ISA definitions
    function automatic logic [31:0] alu_model(input logic [2:0] f3, input logic alt,
                                              input logic [31:0] a, input logic [31:0] b);
        logic [63:0] wide;
        logic [31:0] r;
        wide = {{32{a[31]}}, a} >> b[4:0];
        case (f3)
            3'd0: r = alt ? a - b : a + b;
            3'd1: r = a << b[4:0];
            3'd2: r = (a[31] != b[31]) ? {31'd0, a[31]} : {31'd0, a < b};
            3'd3: r = {31'd0, a < b};
            3'd4: r = a ^ b;
            3'd5: r = alt ? wide[31:0] : a >> b[4:0];
            3'd6: r = a | b;
            default: r = a & b;
        endcase
        return r;
    endfunction

    function automatic logic [31:0] fill_value(input logic [13:0] a);
        return {2'b10, a, 2'b01, ~a};
    endfunction

    ////////////////////////////////////////////////////////////
    // Program building and checking

    task automatic put(input logic [31:0] word);
        rom[n_inst] = word;
        n_inst++;
    endtask

    task automatic load_const(input logic [4:0] rd, input logic [31:0] v);
        logic [31:0] t;
        t = v + 32'h800;
        put(utype(t[31:12], rd));
        put(itype(v[11:0], rd, 3'd0, rd, OPC_IMM));
    endtask

    // Result words land at consecutive RAM words from zero
    task automatic save_result(input logic [4:0] rs, input logic [31:0] v);
        put(stype(12'(4 * expected.size()), rs, 5'd0));
        expected.push_back(v);
    endtask

    task automatic shadow_store(input logic [13:0] word);
        put(stype(12'({word, 2'b00}), 5'd3, 5'd0));
    endtask

    task automatic check_eq(input string name, input logic [31:0] got,
                            input logic [31:0] exp);
        checks++;
        assert (got === exp) else begin
            errors++;
            $display("ERR %0t %s got %h expected %h", $time, name, got, exp);
        end
    endtask

    task automatic start_program();
        @(posedge clk);
        #2;
        arst_n = 1'b0;
        for (int a = 0; a < MEM_WORDS; a++) begin
            rom[a] = NOP;
            ram[a] = fill_value(14'(a));
        end
        n_inst = 0;
        expected.delete();
    endtask

    task automatic run_program(input string name);
        int   cycles;
        logic hit;
        put(stype(12'h7fc, 5'd0, 5'd0));
        for (int c = 0; c < 16; c++) begin
            @(negedge clk);
            check_eq("isram_addr", 32'(isram_addr), '0);
            check_eq("dsram_wen", 32'(dsram_wen), '0);
        end
        @(posedge clk);
        #2;
        arst_n = 1'b1;
        @(negedge clk);
        check_eq("isram_addr", 32'(isram_addr), '0);
        check_eq("dsram_wen", 32'(dsram_wen), '0);
        cycles = 0;
        hit    = 1'b0;
        while (!hit && cycles < 1000) begin
            @(negedge clk);
            cycles++;
            hit = (dsram_wen != 4'd0) && (dsram_addr == END_WORD);
        end
        if (!hit) begin
            timeouts++;
            $display("%s: no store to the end marker after %0d cycles", name, cycles);
        end else begin
            @(posedge clk);
            #2;
            foreach (expected[k]) begin
                check_eq($sformatf("%s ram[%0d]", name, k), ram[k], expected[k]);
            end
        end
    endtask

    ////////////////////////////////////////////////////////////
    // Directed tests

    task automatic alu_ops();
        logic [31:0] a, b;
        logic [11:0] imm;
        logic [19:0] upper;
        start_program();
        a     = $urandom();
        b     = $urandom();
        upper = 20'($urandom());
        load_const(5'd1, a);
        load_const(5'd2, b);
        for (int f = 0; f < 8; f++) begin
            for (int alt = 0; alt < 2; alt++) begin
                if (alt == 0 || f == 0 || f == 5) begin
                    put(rtype((alt == 1) ? 7'h20 : 7'h00, 5'd2, 5'd1, 3'(f), 5'd3));
                    save_result(5'd3, alu_model(3'(f), alt == 1, a, b));
                end
                // Immediate form has no SUBI
                if ((alt == 0) || f == 5) begin
                    if (f == 1 || f == 5) begin
                        imm = {(alt == 1) ? 7'h20 : 7'h00, 5'($urandom())};
                    end else begin
                        imm = 12'($urandom());
                    end
                    put(itype(imm, 5'd1, 3'(f), 5'd4, OPC_IMM));
                    save_result(5'd4, alu_model(3'(f), alt == 1, a, {{20{imm[11]}}, imm}));
                end
            end
        end
        put(utype(upper, 5'd5));
        save_result(5'd5, {upper, 12'h000});
        put(itype(12'h3a5, 5'd1, 3'd0, 5'd0, OPC_IMM));
        save_result(5'd0, '0);
        run_program("alu");
    endtask

    task automatic forwarding_chain();
        logic [31:0] v1, v2, v3, v4, v5, v6;
        start_program();
        v1 = $urandom();
        load_const(5'd1, v1);
        put(itype(12'h155, 5'd1, 3'd0, 5'd2, OPC_IMM));
        v2 = v1 + 32'h155;
        put(rtype(7'h00, 5'd1, 5'd2, 3'd0, 5'd3));
        v3 = v2 + v1;
        put(NOP);
        put(rtype(7'h20, 5'd2, 5'd3, 3'd0, 5'd4));
        v4 = v3 - v2;
        put(NOP);
        put(NOP);
        put(rtype(7'h00, 5'd2, 5'd4, 3'd4, 5'd5));
        v5 = v4 ^ v2;
        put(NOP);
        put(NOP);
        put(NOP);
        put(rtype(7'h00, 5'd3, 5'd5, 3'd6, 5'd6));
        v6 = v5 | v3;
        save_result(5'd6, v6);
        save_result(5'd5, v5);
        save_result(5'd4, v4);
        run_program("forwarding");
    endtask

    task automatic load_use();
        logic [31:0] k;
        logic [31:0] d [4];
        start_program();
        k = $urandom();
        for (int w = 0; w < 4; w++) begin
            d[w]        = $urandom();
            ram[64 + w] = d[w];
        end
        load_const(5'd4, k);
        put(itype(12'h100, 5'd0, 3'd2, 5'd2, OPC_LOAD));
        put(rtype(7'h00, 5'd4, 5'd2, 3'd0, 5'd3));
        save_result(5'd3, d[0] + k);
        put(itype(12'h104, 5'd0, 3'd2, 5'd5, OPC_LOAD));
        put(NOP);
        put(rtype(7'h20, 5'd5, 5'd4, 3'd0, 5'd6));
        save_result(5'd6, k - d[1]);
        put(itype(12'h108, 5'd0, 3'd2, 5'd7, OPC_LOAD));
        put(NOP);
        put(NOP);
        put(rtype(7'h00, 5'd4, 5'd7, 3'd0, 5'd8));
        save_result(5'd8, d[2] + k);
        // Store data straight from a load
        put(itype(12'h10c, 5'd0, 3'd2, 5'd9, OPC_LOAD));
        save_result(5'd9, d[3]);
        run_program("load_use");
    endtask

    task automatic branch_skips();
        start_program();
        put(itype(12'd5, 5'd0, 3'd0, 5'd1, OPC_IMM));
        put(itype(12'd5, 5'd0, 3'd0, 5'd2, OPC_IMM));
        put(itype(12'd7, 5'd0, 3'd0, 5'd3, OPC_IMM));
        put(btype(13'd16, 5'd2, 5'd1, 3'd0));
        shadow_store(14'd16);
        shadow_store(14'd17);
        shadow_store(14'd18);
        save_result(5'd1, 32'd5);
        put(btype(13'd16, 5'd3, 5'd1, 3'd1));
        shadow_store(14'd19);
        shadow_store(14'd20);
        shadow_store(14'd21);
        save_result(5'd3, 32'd7);
        // Not taken so all three followers run
        put(btype(13'd16, 5'd3, 5'd1, 3'd0));
        save_result(5'd1, 32'd5);
        save_result(5'd3, 32'd7);
        save_result(5'd2, 32'd5);
        put(itype(12'd7, 5'd0, 3'd0, 5'd4, OPC_IMM));
        put(btype(13'd12, 5'd3, 5'd4, 3'd0));
        shadow_store(14'd22);
        shadow_store(14'd23);
        save_result(5'd4, 32'd7);
        put(itype(12'd5, 5'd0, 3'd0, 5'd5, OPC_IMM));
        put(btype(13'd12, 5'd1, 5'd5, 3'd1));
        save_result(5'd5, 32'd5);
        save_result(5'd1, 32'd5);
        run_program("branches");
        for (int w = 16; w < 24; w++) begin
            check_eq($sformatf("branches ram[%0d]", w), ram[w], fill_value(14'(w)));
        end
    endtask

    initial begin
        void'($urandom(32'h3b0e6497));
        alu_ops();
        forwarding_chain();
        load_use();
        branch_skips();
        $display("checks %0d, errors %0d, timeouts %0d", checks, errors, timeouts);
        if (errors == 0 && timeouts == 0) begin
            $display("test passed");
        end else begin
            $display("test failed");
        end
        $finish;
    end

endmodule

/* design/cpu.sv */
`timescale 1ns/100ps
`include "cpu_config.svh"

module cpu import cpu_pkg::*; (
    input  logic                   clk,
    input  logic                   arst_n,
    output logic [`CPU_MEM_AW-1:0] isram_addr,
    input  logic [`CPU_XLEN-1:0]   isram_dataout,
    output logic [`CPU_MEM_AW-1:0] dsram_addr,
    output logic [3:0]             dsram_wen,
    output logic [`CPU_XLEN-1:0]   dsram_datain,
    input  logic [`CPU_XLEN-1:0]   dsram_dataout
);

    ////////////////////////////////////////////////////////////
    // Stage interconnect

    inst_t                inst;
    logic [`CPU_XLEN-1:0] inst_pc;
    logic                 inst_valid;
    logic                 stall;
    logic                 branch_taken;
    logic [`CPU_XLEN-1:0] branch_target;
    logic [4:0]           rs1, rs2;
    logic [1:0]           uses_rs;
    logic [`CPU_XLEN-1:0] fwd_rs1, fwd_rs2;
    logic [1:0]           fwd_en;
    de_reg_t              de;
    logic [`CPU_XLEN-1:0] alu_result;
    em_reg_t              em;
    mw_reg_t              m2_fwd;
    wb_req_t              wb;

    ////////////////////////////////////////////////////////////
    // Pipeline

    fetch_stage i_fetch_stage (
        .clk(clk),
        .arst_n(arst_n),
        .stall(stall),
        .branch_taken(branch_taken),
        .branch_target(branch_target),
        .isram_addr(isram_addr),
        .isram_dataout(isram_dataout),
        .inst(inst),
        .inst_pc(inst_pc),
        .inst_valid(inst_valid)
    );

    decode_stage i_decode_stage (
        .clk(clk),
        .arst_n(arst_n),
        .inst(inst),
        .inst_pc(inst_pc),
        .inst_valid(inst_valid),
        .stall(stall),
        .wb(wb),
        .fwd_rs1(fwd_rs1),
        .fwd_rs2(fwd_rs2),
        .fwd_en(fwd_en),
        .rs1(rs1),
        .rs2(rs2),
        .uses_rs(uses_rs),
        .branch_taken(branch_taken),
        .branch_target(branch_target),
        .de(de)
    );

    execute_stage i_execute_stage (
        .clk(clk),
        .arst_n(arst_n),
        .de(de),
        .alu_result(alu_result),
        .em(em)
    );

    memory_stage i_memory_stage (
        .clk(clk),
        .arst_n(arst_n),
        .em(em),
        .dsram_addr(dsram_addr),
        .dsram_wen(dsram_wen),
        .dsram_datain(dsram_datain),
        .dsram_dataout(dsram_dataout),
        .m2_fwd(m2_fwd),
        .wb(wb)
    );

    hazard_unit i_hazard_unit (
        .rs1(rs1),
        .rs2(rs2),
        .uses_rs(uses_rs),
        .de(de),
        .alu_result(alu_result),
        .em(em),
        .m2_fwd(m2_fwd),
        .wb(wb),
        .fwd_rs1(fwd_rs1),
        .fwd_rs2(fwd_rs2),
        .fwd_en(fwd_en),
        .stall(stall)
    );

endmodule

/* design/hazard_unit.sv */
`timescale 1ns/100ps
`include "cpu_config.svh"

module hazard_unit import cpu_pkg::*; (
    input  logic [4:0]           rs1,
    input  logic [4:0]           rs2,
    input  logic [1:0]           uses_rs,
    input  de_reg_t              de,
    input  logic [`CPU_XLEN-1:0] alu_result,
    input  em_reg_t              em,
    input  mw_reg_t              m2_fwd,
    input  wb_req_t              wb,
    output logic [`CPU_XLEN-1:0] fwd_rs1,
    output logic [`CPU_XLEN-1:0] fwd_rs2,
    output logic [1:0]           fwd_en,
    output logic                 stall
);

    typedef struct packed {
        logic                 hit;
        logic                 stall;
        logic [`CPU_XLEN-1:0] value;
    } fwd_t;

    fwd_t src1, src2;

    // Youngest producer wins; load data exists only from M2 on
    function automatic fwd_t lookup(input logic [4:0] rs, input logic used);
        fwd_t r;
        r = '0;
        if (used && rs != 5'd0) begin
            if (de.valid && de.reg_write && de.rd == rs) begin
                r.hit   = 1'b1;
                r.stall = de.is_load;
                r.value = alu_result;
            end else if (em.valid && em.reg_write && em.rd == rs) begin
                r.hit   = 1'b1;
                r.stall = em.is_load;
                r.value = em.result;
            end else if (m2_fwd.valid && m2_fwd.reg_write && m2_fwd.rd == rs) begin
                r.hit   = 1'b1;
                r.value = m2_fwd.result;
            end else if (wb.wen && wb.waddr == rs) begin
                r.hit   = 1'b1;
                r.value = wb.wdata;
            end
        end
        return r;
    endfunction

    always_comb begin
        src1 = lookup(rs1, uses_rs[0]);
        src2 = lookup(rs2, uses_rs[1]);
    end

    assign fwd_rs1 = src1.value;
    assign fwd_rs2 = src2.value;
    assign fwd_en  = {src2.hit, src1.hit};
    assign stall   = src1.stall | src2.stall;

endmodule

/* design/memory_stage.sv */
`timescale 1ns/100ps
`include "cpu_config.svh"

module memory_stage import cpu_pkg::*; (
    input  logic                   clk,
    input  logic                   arst_n,
    input  em_reg_t                em,
    output logic [`CPU_MEM_AW-1:0] dsram_addr,
    output logic [3:0]             dsram_wen,
    output logic [`CPU_XLEN-1:0]   dsram_datain,
    input  logic [`CPU_XLEN-1:0]   dsram_dataout,
    output mw_reg_t                m2_fwd,
    output wb_req_t                wb
);

    mw_reg_t m2_q;
    mw_reg_t wb_q;

    // Word accesses only, so all four lanes move together
    assign dsram_addr   = em.result[`CPU_MEM_AW+1:2];
    assign dsram_wen    = {4{em.valid & em.is_store}};
    assign dsram_datain = em.store_data;

    always_comb begin
        m2_fwd = m2_q;
        if (m2_q.is_load) begin
            m2_fwd.result = dsram_dataout;
        end
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            m2_q <= '0;
            wb_q <= '0;
        end else begin
            m2_q.valid     <= em.valid;
            m2_q.result    <= em.result;
            m2_q.is_load   <= em.is_load;
            m2_q.reg_write <= em.reg_write;
            m2_q.rd        <= em.rd;
            wb_q           <= m2_fwd;
        end
    end

    assign wb.wen   = wb_q.valid & wb_q.reg_write & (wb_q.rd != 5'd0);
    assign wb.waddr = wb_q.rd;
    assign wb.wdata = wb_q.result;

endmodule

/* design/execute_stage.sv */
`timescale 1ns/100ps
`include "cpu_config.svh"

module execute_stage import cpu_pkg::*; (
    input  logic                 clk,
    input  logic                 arst_n,
    input  de_reg_t              de,
    output logic [`CPU_XLEN-1:0] alu_result,
    output em_reg_t              em
);

    logic [`CPU_XLEN-1:0] a, b;

    assign a = de.operand_a;
    assign b = de.operand_b;

    // Loads and stores arrive with ALU_ADD to form the address
    always_comb begin
        case (de.alu_op)
            ALU_ADD:  alu_result = a + b;
            ALU_SUB:  alu_result = a - b;
            ALU_AND:  alu_result = a & b;
            ALU_OR:   alu_result = a | b;
            ALU_XOR:  alu_result = a ^ b;
            ALU_SLL:  alu_result = a << b[4:0];
            ALU_SRL:  alu_result = a >> b[4:0];
            ALU_SRA:  alu_result = $signed(a) >>> b[4:0];
            ALU_SLT:  alu_result = `CPU_XLEN'($signed(a) < $signed(b));
            ALU_SLTU: alu_result = `CPU_XLEN'(a < b);
            default:  alu_result = a + b;
        endcase
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            em <= '0;
        end else begin
            em.valid      <= de.valid;
            em.result     <= alu_result;
            em.store_data <= de.store_data;
            em.is_load    <= de.is_load;
            em.is_store   <= de.is_store;
            em.reg_write  <= de.reg_write;
            em.rd         <= de.rd;
        end
    end

endmodule

/* design/decode_stage.sv */
`timescale 1ns/100ps
`include "cpu_config.svh"

module decode_stage import cpu_pkg::*; (
    input  logic                 clk,
    input  logic                 arst_n,
    input  inst_t                inst,
    input  logic [`CPU_XLEN-1:0] inst_pc,
    input  logic                 inst_valid,
    input  logic                 stall,
    input  wb_req_t              wb,
    input  logic [`CPU_XLEN-1:0] fwd_rs1,
    input  logic [`CPU_XLEN-1:0] fwd_rs2,
    input  logic [1:0]           fwd_en,
    output logic [4:0]           rs1,
    output logic [4:0]           rs2,
    output logic [1:0]           uses_rs,
    output logic                 branch_taken,
    output logic [`CPU_XLEN-1:0] branch_target,
    output de_reg_t              de
);

    logic [`CPU_XLEN-1:0] regs [`CPU_NREGS];
    logic                 is_op, is_op_imm, is_lui, is_load, is_store, is_branch;
    logic                 reg_write;
    logic [`CPU_XLEN-1:0] imm;
    logic [`CPU_XLEN-1:0] b_imm;
    logic [`CPU_XLEN-1:0] rf_rs1, rf_rs2;
    logic [`CPU_XLEN-1:0] rs1_val, rs2_val;
    alu_op_e              alu_op;

    assign is_op     = inst.r.opcode == OP;
    assign is_op_imm = inst.i.opcode == OP_IMM;
    assign is_lui    = inst.u.opcode == LUI;
    assign is_load   = inst.i.opcode == LOAD;
    assign is_store  = inst.s.opcode == STORE;
    assign is_branch = inst.b.opcode == BRANCH;
    assign reg_write = is_op | is_op_imm | is_lui | is_load;

    assign rs1     = inst.r.rs1;
    assign rs2     = inst.r.rs2;
    assign uses_rs = {is_op | is_store | is_branch,
                      is_op | is_op_imm | is_load | is_store | is_branch};

    always_comb begin
        if (is_lui) begin
            imm = {inst.u.imm, 12'b0};
        end else if (is_store) begin
            imm = {{20{inst.s.imm_hi[6]}}, inst.s.imm_hi, inst.s.imm_lo};
        end else begin
            imm = {{20{inst.i.imm[11]}}, inst.i.imm};
        end
    end

    // SUB only exists in the register form, SRA in both
    always_comb begin
        alu_op = ALU_ADD;
        if (is_op || is_op_imm) begin
            case (inst.r.funct3)
                3'd0: alu_op = (is_op && inst.r.funct7[5]) ? ALU_SUB : ALU_ADD;
                3'd1: alu_op = ALU_SLL;
                3'd2: alu_op = ALU_SLT;
                3'd3: alu_op = ALU_SLTU;
                3'd4: alu_op = ALU_XOR;
                3'd5: alu_op = inst.r.funct7[5] ? ALU_SRA : ALU_SRL;
                3'd6: alu_op = ALU_OR;
                3'd7: alu_op = ALU_AND;
            endcase
        end
    end

    ////////////////////////////////////////////////////////////
    // Register file

    always_ff @(posedge clk) begin
        if (wb.wen) begin
            regs[wb.waddr] <= wb.wdata;
        end
    end

    assign rf_rs1  = (rs1 == 5'd0) ? '0 : regs[rs1];
    assign rf_rs2  = (rs2 == 5'd0) ? '0 : regs[rs2];
    assign rs1_val = fwd_en[0] ? fwd_rs1 : rf_rs1;
    assign rs2_val = fwd_en[1] ? fwd_rs2 : rf_rs2;

    ////////////////////////////////////////////////////////////
    // Branch resolution for BEQ and BNE

    assign b_imm = {{19{inst.b.imm_12}}, inst.b.imm_12, inst.b.imm_11,
                    inst.b.imm_10_5, inst.b.imm_4_1, 1'b0};
    assign branch_target = inst_pc + b_imm;
    assign branch_taken  = inst_valid & ~stall & is_branch & (inst.b.funct3[2:1] == 2'b00)
                         & ((rs1_val == rs2_val) ^ inst.b.funct3[0]);

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            de <= '0;
        end else if (stall || !inst_valid) begin
            de <= '0;
        end else begin
            de.valid      <= 1'b1;
            de.alu_op     <= alu_op;
            de.operand_a  <= is_lui ? '0 : rs1_val;
            de.operand_b  <= is_op ? rs2_val : imm;
            de.store_data <= rs2_val;
            de.is_load    <= is_load;
            de.is_store   <= is_store;
            de.reg_write  <= reg_write;
            de.rd         <= inst.r.rd;
        end
    end

endmodule

/* design/fetch_stage.sv */
`timescale 1ns/100ps
`include "cpu_config.svh"

module fetch_stage import cpu_pkg::*; (
    input  logic                  clk,
    input  logic                  arst_n,
    input  logic                  stall,
    input  logic                  branch_taken,
    input  logic [`CPU_XLEN-1:0]  branch_target,
    output logic [`CPU_MEM_AW-1:0] isram_addr,
    input  inst_t                 isram_dataout,
    output inst_t                 inst,
    output logic [`CPU_XLEN-1:0]  inst_pc,
    output logic                  inst_valid
);

    logic [`CPU_XLEN-1:0] pc;
    logic [`CPU_XLEN-1:0] f2_pc;
    logic                 f2_valid;

    // While stalled, re-read the F2 word so it is still there afterwards
    assign isram_addr = stall ? f2_pc[`CPU_MEM_AW+1:2] : pc[`CPU_MEM_AW+1:2];

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            pc         <= `CPU_RESET_PC;
            f2_valid   <= 1'b0;
            inst_valid <= 1'b0;
        end else if (branch_taken) begin
            pc         <= branch_target;
            f2_valid   <= 1'b0;
            inst_valid <= 1'b0;
        end else if (!stall) begin
            pc         <= pc + 'd4;
            f2_valid   <= 1'b1;
            inst_valid <= f2_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (!stall) begin
            f2_pc   <= pc;
            inst    <= isram_dataout;
            inst_pc <= f2_pc;
        end
    end

endmodule

/* design/cpu_pkg.sv */
`include "cpu_config.svh"

package cpu_pkg;

    typedef enum logic [6:0] {
        OP     = 7'b0110011,
        OP_IMM = 7'b0010011,
        LUI    = 7'b0110111,
        LOAD   = 7'b0000011,
        STORE  = 7'b0100011,
        BRANCH = 7'b1100011
    } opcode_e;

    typedef enum logic [3:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_AND,
        ALU_OR,
        ALU_XOR,
        ALU_SLL,
        ALU_SRL,
        ALU_SRA,
        ALU_SLT,
        ALU_SLTU
    } alu_op_e;

    ////////////////////////////////////////////////////////////
    // Instruction formats

    typedef struct packed {
        logic [6:0] funct7;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [4:0] rd;
        opcode_e    opcode;
    } r_inst_t;

    typedef struct packed {
        logic [11:0] imm;
        logic [4:0]  rs1;
        logic [2:0]  funct3;
        logic [4:0]  rd;
        opcode_e     opcode;
    } i_inst_t;

    typedef struct packed {
        logic [6:0] imm_hi;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [4:0] imm_lo;
        opcode_e    opcode;
    } s_inst_t;

    typedef struct packed {
        logic       imm_12;
        logic [5:0] imm_10_5;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [3:0] imm_4_1;
        logic       imm_11;
        opcode_e    opcode;
    } b_inst_t;

    typedef struct packed {
        logic [19:0] imm;
        logic [4:0]  rd;
        opcode_e     opcode;
    } u_inst_t;

    typedef union packed {
        r_inst_t r;
        i_inst_t i;
        s_inst_t s;
        b_inst_t b;
        u_inst_t u;
    } inst_t;

    ////////////////////////////////////////////////////////////
    // Stage payloads

    typedef struct packed {
        logic                 valid;
        alu_op_e              alu_op;
        logic [`CPU_XLEN-1:0] operand_a;
        logic [`CPU_XLEN-1:0] operand_b;
        logic [`CPU_XLEN-1:0] store_data;
        logic                 is_load;
        logic                 is_store;
        logic                 reg_write;
        logic [4:0]           rd;
    } de_reg_t;

    typedef struct packed {
        logic                 valid;
        logic [`CPU_XLEN-1:0] result;
        logic [`CPU_XLEN-1:0] store_data;
        logic                 is_load;
        logic                 is_store;
        logic                 reg_write;
        logic [4:0]           rd;
    } em_reg_t;

    typedef struct packed {
        logic                 valid;
        logic [`CPU_XLEN-1:0] result;
        logic                 is_load;
        logic                 reg_write;
        logic [4:0]           rd;
    } mw_reg_t;

    typedef struct packed {
        logic                 wen;
        logic [4:0]           waddr;
        logic [`CPU_XLEN-1:0] wdata;
    } wb_req_t;

endpackage

/* design/cpu_config.svh */
`ifndef CPU_CONFIG_SVH
`define CPU_CONFIG_SVH

// Data path and address width
`define CPU_XLEN 32

// Word address bits at both SRAM ports
`define CPU_MEM_AW 14

// First fetch address out of reset
`define CPU_RESET_PC 0

// Integer register count including x0
`define CPU_NREGS 32

`endif
